//--- include/mem_unit_defines.svh
// Address map and clock constants of the memory-mapped I/O unit
// Include wherever a register address or a clock divisor default is needed
`ifndef MEM_UNIT_DEFINES_SVH
`define MEM_UNIT_DEFINES_SVH

// ===========================================================================
// Address map, in CPU words
// ===========================================================================
`define IO_BASE             (32'h7000000)  // Start of the I/O window

`define ADDR_UART_TX        (32'h00)
`define ADDR_TIMER_VALUE    (32'h02)       // Reload value in microseconds
`define ADDR_TIMER_START    (32'h03)
`define ADDR_SPI_DATA       (32'h08)
`define ADDR_SPI_CS         (32'h09)
`define ADDR_BOOT_MODE      (32'h19)
`define ADDR_MICROS         (32'h1A)

// ===========================================================================
// Clock divisors
// ===========================================================================
`define UART_CLKS_PER_BIT       8      // Short bit time for simulation
`define SPI_CLKS_PER_HALF_BIT   2
`define CLKS_PER_US             10

`endif

//--- logic/io_bus_fsm.sv
// Address decoder and request FSM between the CPU and the peripherals
// Accepts one start pulse in IDLE and answers with a one-cycle done and q
`timescale 1ns/1ps
`include "mem_unit_defines.svh"

module io_bus_fsm (
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   start,
    input  mem_unit_pkg::io_addr_t addr,
    input  mem_unit_pkg::word_t    data,
    input  logic                   we,
    input  logic                   boot_mode,
    input  mem_unit_pkg::word_t    micros,
    input  logic                   tx_done,
    input  logic                   spi_done,
    input  mem_unit_pkg::byte_t    spi_rx_byte,
    output mem_unit_pkg::word_t    q,
    output logic                   done,
    output logic                   tx_start,
    output mem_unit_pkg::byte_t    tx_byte,
    output logic                   spi_start,
    output mem_unit_pkg::byte_t    spi_tx_byte,
    output logic                   spi_cs,
    output logic                   timer_set,
    output mem_unit_pkg::word_t    timer_value,
    output logic                   timer_trigger
);

    import mem_unit_pkg::*;

    bus_state_e state;
    logic       spi_wait;   // SPI data write still in flight

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            state         <= IDLE;
            q             <= '0;
            done          <= 1'b0;
            tx_start      <= 1'b0;
            spi_start     <= 1'b0;
            spi_cs        <= 1'b1;   // Deselected
            spi_wait      <= 1'b0;
            timer_set     <= 1'b0;
            timer_trigger <= 1'b0;
        end
        else
        begin
            // Pulses and q default low
            q             <= '0;
            done          <= 1'b0;
            tx_start      <= 1'b0;
            spi_start     <= 1'b0;
            timer_set     <= 1'b0;
            timer_trigger <= 1'b0;

            case (state)
                // ===========================================================
                // Decode and launch
                // ===========================================================
                IDLE:
                begin
                    if (start)
                    begin
                        case (addr)
                            `IO_BASE + `ADDR_UART_TX:
                            begin
                                tx_byte  <= data[7:0];
                                tx_start <= 1'b1;
                                state    <= WAIT_UART;
                            end
                            `IO_BASE + `ADDR_TIMER_VALUE:
                            begin
                                timer_value <= data;
                                timer_set   <= 1'b1;
                                state       <= RETURN_ZERO;
                            end
                            `IO_BASE + `ADDR_TIMER_START:
                            begin
                                timer_trigger <= 1'b1;
                                state         <= RETURN_ZERO;
                            end
                            `IO_BASE + `ADDR_SPI_DATA:
                            begin
                                if (we)
                                begin
                                    spi_tx_byte <= data[7:0];
                                    spi_start   <= 1'b1;
                                end
                                spi_wait <= we;   // A read returns the last byte
                                state    <= WAIT_SPI;
                            end
                            `IO_BASE + `ADDR_SPI_CS:
                            begin
                                if (we)
                                    spi_cs <= data[0];
                                state <= READ_CS;
                            end
                            `IO_BASE + `ADDR_BOOT_MODE:
                                state <= READ_BOOT;
                            `IO_BASE + `ADDR_MICROS:
                                state <= READ_MICROS;
                            default:
                                state <= RETURN_ZERO;   // Nothing behind this address
                        endcase
                    end
                end

                // ===========================================================
                // Reply
                // ===========================================================
                WAIT_UART:
                begin
                    if (tx_done)
                    begin
                        done  <= 1'b1;
                        state <= IDLE;
                    end
                end

                WAIT_SPI:
                begin
                    if (!spi_wait || spi_done)
                    begin
                        done     <= 1'b1;
                        q        <= {24'd0, spi_rx_byte};
                        spi_wait <= 1'b0;
                        state    <= IDLE;
                    end
                end

                READ_CS:
                begin
                    done  <= 1'b1;
                    q     <= {31'd0, spi_cs};
                    state <= IDLE;
                end

                READ_BOOT:
                begin
                    done  <= 1'b1;
                    q     <= {31'd0, boot_mode};
                    state <= IDLE;
                end

                READ_MICROS:
                begin
                    done  <= 1'b1;
                    q     <= micros;
                    state <= IDLE;
                end

                RETURN_ZERO:
                begin
                    done  <= 1'b1;
                    state <= IDLE;
                end

                default:
                    state <= IDLE;
            endcase
        end
    end

    a_done_single: assert property (@(posedge clk) disable iff (reset) done |=> !done)
        else $error("done high on two consecutive cycles");

    // Chip select must hold across a whole SPI byte
    a_cs_stable: assert property (@(posedge clk) disable iff (reset)
        (state == WAIT_SPI) |-> $stable(spi_cs))
        else $error("spi_cs changed during an SPI transfer");

endmodule

//--- logic/mem_unit_pkg.sv
// Shared types of the I/O unit
// Modules import it inside their body and use scoped names in port lists

package mem_unit_pkg;

    typedef logic [31:0] word_t;     // CPU data and read data
    typedef logic [7:0]  byte_t;     // UART or SPI byte
    typedef logic [31:0] io_addr_t;  // CPU word address

    // One request at a time through the bus FSM
    typedef enum logic [2:0] {
        IDLE,
        RETURN_ZERO,    // Unmapped address or write-only register
        WAIT_UART,
        WAIT_SPI,
        READ_CS,
        READ_BOOT,
        READ_MICROS
    } bus_state_e;

endpackage

//--- logic/memory_unit.sv
// Top level of the I/O unit with the bus FSM and its peripherals
// CPU side is a start/done handshake, one request outstanding at a time
`timescale 1ns/1ps

module memory_unit (
    input  logic                   clk,
    input  logic                   reset,

    // CPU side
    input  logic                   start,
    input  mem_unit_pkg::io_addr_t addr,
    input  mem_unit_pkg::word_t    data,
    input  logic                   we,
    output mem_unit_pkg::word_t    q,
    output logic                   done,

    // Peripheral pins
    input  logic                   boot_mode,
    output logic                   uart_tx,
    output logic                   timer_int,
    output logic                   spi_clk,
    output logic                   spi_cs,
    output logic                   spi_mosi,
    input  logic                   spi_miso
);

    import mem_unit_pkg::*;

    logic  tx_start, tx_done;
    byte_t tx_byte;
    logic  spi_start, spi_done;
    byte_t spi_tx_byte, spi_rx_byte;
    logic  timer_set, timer_trigger;
    word_t timer_value;
    logic  us_tick;
    word_t micros;

    io_bus_fsm bus0 (
        .clk           (clk),
        .reset         (reset),
        .start         (start),
        .addr          (addr),
        .data          (data),
        .we            (we),
        .boot_mode     (boot_mode),
        .micros        (micros),
        .tx_done       (tx_done),
        .spi_done      (spi_done),
        .spi_rx_byte   (spi_rx_byte),
        .q             (q),
        .done          (done),
        .tx_start      (tx_start),
        .tx_byte       (tx_byte),
        .spi_start     (spi_start),
        .spi_tx_byte   (spi_tx_byte),
        .spi_cs        (spi_cs),
        .timer_set     (timer_set),
        .timer_value   (timer_value),
        .timer_trigger (timer_trigger)
    );

    uart_tx uart0 (
        .clk      (clk),
        .reset    (reset),
        .tx_start (tx_start),
        .tx_byte  (tx_byte),
        .tx_done  (tx_done),
        .uart_tx  (uart_tx)
    );

    spi_master spi0 (
        .clk         (clk),
        .reset       (reset),
        .spi_start   (spi_start),
        .spi_tx_byte (spi_tx_byte),
        .spi_miso    (spi_miso),
        .spi_done    (spi_done),
        .spi_rx_byte (spi_rx_byte),
        .spi_clk     (spi_clk),
        .spi_mosi    (spi_mosi)
    );

    os_timer timer0 (
        .clk           (clk),
        .reset         (reset),
        .us_tick       (us_tick),
        .timer_set     (timer_set),
        .timer_value   (timer_value),
        .timer_trigger (timer_trigger),
        .timer_int     (timer_int)
    );

    micros_counter micros0 (
        .clk     (clk),
        .reset   (reset),
        .us_tick (us_tick),
        .micros  (micros)
    );

endmodule

//--- logic/micros_counter.sv
// Microsecond time base with a prescaler tick and a free-running 32-bit count
// The count wraps at 2^32
`timescale 1ns/1ps
`include "mem_unit_defines.svh"

module micros_counter #(
    parameter int CLKS_PER_US = `CLKS_PER_US
) (
    input  logic                clk,
    input  logic                reset,
    output logic                us_tick,
    output mem_unit_pkg::word_t micros
);

    logic [$clog2(CLKS_PER_US + 1)-1:0] prescale;

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            prescale <= '0;
            us_tick  <= 1'b0;
            micros   <= '0;
        end
        else if (prescale == CLKS_PER_US - 1)
        begin
            prescale <= '0;
            us_tick  <= 1'b1;
            micros   <= micros + 1'b1;
        end
        else
        begin
            prescale <= prescale + 1'b1;
            us_tick  <= 1'b0;
        end
    end

endmodule

//--- logic/os_timer.sv
// One-shot countdown timer in microsecond ticks
// timer_set loads the reload value, timer_trigger starts a countdown from it
`timescale 1ns/1ps

module os_timer (
    input  logic                clk,
    input  logic                reset,
    input  logic                us_tick,
    input  logic                timer_set,
    input  mem_unit_pkg::word_t timer_value,
    input  logic                timer_trigger,
    output logic                timer_int
);

    import mem_unit_pkg::*;

    word_t reload;
    word_t count;
    logic  running;

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            reload    <= '0;
            running   <= 1'b0;
            timer_int <= 1'b0;
        end
        else
        begin
            timer_int <= 1'b0;
            if (timer_set)
                reload <= timer_value;

            if (timer_trigger)
            begin
                count   <= reload;    // Restarts a running countdown too
                running <= 1'b1;
            end
            else if (running && us_tick)
            begin
                if (count == '0)
                begin
                    timer_int <= 1'b1;
                    running   <= 1'b0;
                end
                else
                    count <= count - 1'b1;
            end
        end
    end

endmodule

//--- logic/spi_master.sv
// Mode 0 SPI byte shifter, MSB first, eight clocks per transfer
// One spi_start pulse runs one byte; the received byte holds until the next one
`timescale 1ns/1ps
`include "mem_unit_defines.svh"

module spi_master #(
    parameter int CLKS_PER_HALF_BIT = `SPI_CLKS_PER_HALF_BIT
) (
    input  logic                clk,
    input  logic                reset,
    input  logic                spi_start,
    input  mem_unit_pkg::byte_t spi_tx_byte,
    input  logic                spi_miso,
    output logic                spi_done,
    output mem_unit_pkg::byte_t spi_rx_byte,
    output logic                spi_clk,
    output logic                spi_mosi
);

    import mem_unit_pkg::*;

    logic                                       busy;
    logic [$clog2(CLKS_PER_HALF_BIT + 1)-1:0]   half_cnt;
    logic [4:0]                                 edge_cnt;  // 16 edges per byte
    byte_t                                      tx_shift;
    byte_t                                      rx_shift;

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            busy        <= 1'b0;
            spi_done    <= 1'b0;
            spi_clk     <= 1'b0;
            spi_mosi    <= 1'b0;
            spi_rx_byte <= '0;
            half_cnt    <= '0;
            edge_cnt    <= '0;
        end
        else
        begin
            spi_done <= 1'b0;
            if (!busy)
            begin
                if (spi_start)
                begin
                    busy     <= 1'b1;
                    spi_mosi <= spi_tx_byte[7];   // Set up before first rising edge
                    tx_shift <= {spi_tx_byte[6:0], 1'b0};
                    half_cnt <= '0;
                    edge_cnt <= '0;
                end
            end
            else if (half_cnt == CLKS_PER_HALF_BIT - 1)
            begin
                half_cnt <= '0;
                edge_cnt <= edge_cnt + 5'd1;
                spi_clk  <= ~spi_clk;
                if (!spi_clk)
                begin
                    rx_shift <= {rx_shift[6:0], spi_miso};  // Rising edge sample
                end
                else if (edge_cnt == 5'd15)
                begin
                    // Last falling edge
                    busy        <= 1'b0;
                    spi_done    <= 1'b1;
                    spi_rx_byte <= rx_shift;
                end
                else
                begin
                    spi_mosi <= tx_shift[7];
                    tx_shift <= {tx_shift[6:0], 1'b0};
                end
            end
            else
            begin
                half_cnt <= half_cnt + 1'b1;
            end
        end
    end

    a_clk_idle_low: assert property (@(posedge clk) disable iff (reset) !busy |-> !spi_clk)
        else $error("spi_clk high while master idle");

endmodule

//--- logic/uart_tx.sv
// 8N1 serial transmitter, one byte per tx_start pulse
// tx_done pulses once the stop bit has been on the line for a full bit time
`timescale 1ns/1ps
`include "mem_unit_defines.svh"

module uart_tx #(
    parameter int CLKS_PER_BIT = `UART_CLKS_PER_BIT
) (
    input  logic                clk,
    input  logic                reset,
    input  logic                tx_start,
    input  mem_unit_pkg::byte_t tx_byte,
    output logic                tx_done,
    output logic                uart_tx
);

    logic                                  busy;
    logic [8:0]                            shifter;   // Stop bit above the data
    logic [3:0]                            bit_cnt;   // Bits already on the line
    logic [$clog2(CLKS_PER_BIT + 1)-1:0]   clk_cnt;

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            busy    <= 1'b0;
            tx_done <= 1'b0;
            uart_tx <= 1'b1;
            bit_cnt <= '0;
            clk_cnt <= '0;
        end
        else
        begin
            tx_done <= 1'b0;
            if (!busy)
            begin
                if (tx_start)
                begin
                    busy    <= 1'b1;
                    shifter <= {1'b1, tx_byte};
                    uart_tx <= 1'b0;              // Start bit
                    bit_cnt <= '0;
                    clk_cnt <= '0;
                end
            end
            else if (clk_cnt == CLKS_PER_BIT - 1)
            begin
                clk_cnt <= '0;
                if (bit_cnt == 4'd9)
                begin
                    // End of stop bit, line already high
                    busy    <= 1'b0;
                    tx_done <= 1'b1;
                end
                else
                begin
                    uart_tx <= shifter[0];        // LSB first
                    shifter <= {1'b1, shifter[8:1]};
                    bit_cnt <= bit_cnt + 4'd1;
                end
            end
            else
            begin
                clk_cnt <= clk_cnt + 1'b1;
            end
        end
    end

    a_line_idle_high: assert property (@(posedge clk) disable iff (reset) !busy |-> uart_tx)
        else $error("uart_tx low while transmitter idle");

endmodule

//--- run.sh
#!/bin/sh
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -f sim.f --top-module tb_memory_unit &&
./obj_dir/Vtb_memory_unit || exit 1

//--- sim.f
+incdir+include
logic/mem_unit_pkg.sv
logic/uart_tx.sv
logic/spi_master.sv
logic/os_timer.sv
logic/micros_counter.sv
logic/io_bus_fsm.sv
logic/memory_unit.sv
tb/tb_clock_gen.sv
tb/tb_memory_unit.sv

//--- tb/tb_clock_gen.sv
// Testbench clock and reset source for the I/O unit
// 8 ns clock, reset held high for the first 4 rising edges
`timescale 1ns/1ps

module tb_clock_gen (
    output logic clk,
    output logic reset
);

    initial
    begin
        clk   = 1'b0;
        reset = 1'b1;
        forever #4 clk = ~clk;
    end

    initial
    begin
        repeat (4) @(posedge clk);
        reset <= 1'b0;
    end

endmodule

//--- tb/tb_memory_unit.sv
// Testbench top for the memory-mapped I/O unit
// Runs bus requests against every register, models an SPI slave and decodes UART frames
// Concurrent assertions check every response
`timescale 1ns/1ps
`include "mem_unit_defines.svh"

module tb_memory_unit;

    import mem_unit_pkg::*;

    localparam int KIND_REG     = 0;
    localparam int KIND_UART    = 1;
    localparam int KIND_SPI_WR  = 2;
    localparam int KIND_CS      = 3;
    localparam int KIND_MICROS1 = 4;
    localparam int KIND_MICROS2 = 5;

    localparam int TIMER_N    = 5;
    localparam int MICROS_GAP = 137;
    localparam int UART_LAT   = 10 * `UART_CLKS_PER_BIT + 4;
    localparam int SPI_LAT    = 16 * `SPI_CLKS_PER_HALF_BIT + 4;
    localparam int TIMER_LAT  = (TIMER_N + 1) * `CLKS_PER_US + 4 + 30;
    localparam int WATCHDOG_CYCLES =
        3 * (UART_LAT + SPI_LAT + TIMER_LAT + MICROS_GAP + 20 * 2) + 2000;

    logic     clk, reset;
    logic     start = 1'b0;
    io_addr_t addr = '0;
    word_t    data = '0;
    logic     we = 1'b0;
    logic     boot_mode = 1'b0;
    logic     spi_miso = 1'b0;
    word_t    q;
    logic     done, uart_tx, timer_int, spi_clk, spi_cs, spi_mosi;

    // Request bookkeeping seen by the assertions
    int       req_kind = KIND_REG;
    logic     fixed_req = 1'b0;
    logic     check_q = 1'b0;
    word_t    exp_q = '0;
    byte_t    exp_byte = '0;
    integer   seed = 32'h8b3b6d72;
    longint   cycle = 0;

    tb_clock_gen clkgen0 (.clk(clk), .reset(reset));

    memory_unit dut0 (
        .clk(clk), .reset(reset), .start(start), .addr(addr), .data(data), .we(we),
        .q(q), .done(done), .boot_mode(boot_mode), .uart_tx(uart_tx),
        .timer_int(timer_int), .spi_clk(spi_clk), .spi_cs(spi_cs),
        .spi_mosi(spi_mosi), .spi_miso(spi_miso)
    );

    task automatic fail_run(input string what);
        $display("%s", what);
        $display("*** TEST FAILED ***");
        $fatal(1, "run stopped");
    endtask

    // ========================================================================
    // SPI slave model in mode 0
    // ========================================================================
    logic  slave_load = 1'b0;
    byte_t slave_next = '0;
    byte_t slave_shift = '0;
    byte_t mosi_bits = '0;
    logic  spi_clk_q = 1'b0;

    always @(posedge clk)
    begin
        spi_clk_q <= spi_clk;
        cycle     <= cycle + 1;
        if (slave_load)
        begin
            slave_shift <= slave_next;
            spi_miso    <= slave_next[7];    // First bit ready before first rise
        end
        else if (!spi_clk && spi_clk_q)
        begin
            slave_shift <= {slave_shift[6:0], 1'b0};
            spi_miso    <= slave_shift[6];
        end
        if (spi_clk && !spi_clk_q)
            mosi_bits <= {mosi_bits[6:0], spi_mosi};
    end

    // ========================================================================
    // UART decoder sampling at bit centres
    // ========================================================================
    byte_t uart_byte = '0;
    logic  uart_frame_ok = 1'b0;

    initial
    begin
        forever
        begin
            @(negedge uart_tx);
            uart_frame_ok = 1'b0;
            repeat (`UART_CLKS_PER_BIT / 2) @(negedge clk);
            for (int i = 0; i < 8; i++)
            begin
                repeat (`UART_CLKS_PER_BIT) @(negedge clk);
                uart_byte[i] = uart_tx;   // LSB first
            end
            repeat (`UART_CLKS_PER_BIT) @(negedge clk);
            uart_frame_ok = uart_tx;      // Stop bit
        end
    end

    // Timer and micros monitors
    logic   timer_armed = 1'b0;
    longint trig_cycle = 0;
    word_t  micros_first = '0;
    longint micros_cycle = 0;

    always @(posedge clk)
    begin
        if (start && addr == `IO_BASE + `ADDR_TIMER_START)
        begin
            timer_armed <= 1'b1;
            trig_cycle  <= cycle;
        end
        else if (timer_int)
            timer_armed <= 1'b0;
        if (done && req_kind == KIND_MICROS1)
        begin
            micros_first <= q;
            micros_cycle <= cycle;
        end
    end

    function automatic logic micros_in_range(input word_t diff, input longint gap);
        longint lo;
        longint hi;
        lo = gap / `CLKS_PER_US - 1;
        hi = (gap + `CLKS_PER_US - 1) / `CLKS_PER_US + 1;
        return (longint'(diff) >= lo) && (longint'(diff) <= hi);
    endfunction

    // ========================================================================
    // Checks
    // ========================================================================
    a_reset_outputs: assert property (@(posedge clk) $fell(reset) |->
        !done && q == '0 && spi_cs && uart_tx && !spi_clk && !timer_int)
        else fail_run($sformatf(
            "ERROR reset state: done %h q %h spi_cs %h uart_tx %h spi_clk %h timer_int %h",
            done, q, spi_cs, uart_tx, spi_clk, timer_int));

    a_fixed_latency: assert property (@(posedge clk) disable iff (reset)
        start && fixed_req |=> !done ##1 done)
        else fail_run("done did not arrive exactly one cycle after the request");

    a_q_value: assert property (@(posedge clk) disable iff (reset)
        done && check_q |-> q == exp_q)
        else fail_run($sformatf("ERROR q: got %h expected %h", q, exp_q));

    a_uart_frame: assert property (@(posedge clk) disable iff (reset)
        done && req_kind == KIND_UART |-> uart_frame_ok && uart_byte == exp_byte)
        else fail_run($sformatf("ERROR uart_tx byte: got %h expected %h stop %h",
            uart_byte, exp_byte, uart_frame_ok));

    a_spi_mosi: assert property (@(posedge clk) disable iff (reset)
        done && req_kind == KIND_SPI_WR |-> mosi_bits == exp_byte)
        else fail_run($sformatf("ERROR spi_mosi byte: got %h expected %h",
            mosi_bits, exp_byte));

    a_spi_cs: assert property (@(posedge clk) disable iff (reset)
        done && req_kind == KIND_CS |-> spi_cs == exp_q[0])
        else fail_run($sformatf("ERROR spi_cs: got %h expected %h", spi_cs, exp_q[0]));

    // Interrupt window measured from edge k+1 of the timer start request
    a_timer_window: assert property (@(posedge clk) disable iff (reset)
        timer_int |-> timer_armed
        && (cycle - trig_cycle - 2) >= TIMER_N * `CLKS_PER_US
        && (cycle - trig_cycle - 2) <= (TIMER_N + 1) * `CLKS_PER_US + 4)
        else fail_run($sformatf("ERROR timer_int: cycles %h armed %h",
            cycle - trig_cycle - 2, timer_armed));

    a_micros_delta: assert property (@(posedge clk) disable iff (reset)
        done && req_kind == KIND_MICROS2 |->
        micros_in_range(q - micros_first, cycle - micros_cycle))
        else fail_run($sformatf("ERROR micros delta: got %h over %h cycles",
            q - micros_first, cycle - micros_cycle));

    // ========================================================================
    // Stimulus
    // ========================================================================
    task automatic bus_request(input io_addr_t a, input word_t d, input logic w,
                               input int kind, input logic fixed, input logic check,
                               input word_t expv);
        @(posedge clk);
        start     <= 1'b1;
        addr      <= a;
        data      <= d;
        we        <= w;
        req_kind  <= kind;
        fixed_req <= fixed;
        check_q   <= check;
        exp_q     <= expv;
        @(posedge clk);
        start <= 1'b0;
        @(negedge clk);
        while (done !== 1'b1)
            @(negedge clk);
    endtask

    initial
    begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        fail_run("Watchdog expired before all tests finished");
    end

    initial
    begin
        byte_t rnd;
        @(negedge reset);
        repeat (2) @(posedge clk);

        // Register requests and read-as-zero
        bus_request(`IO_BASE + 32'h05, '0, 1'b0, KIND_REG, 1'b1, 1'b1, '0);
        bus_request(32'h100, 32'hdead, 1'b1, KIND_REG, 1'b1, 1'b1, '0);
        bus_request(`IO_BASE + `ADDR_SPI_CS, '0, 1'b0, KIND_CS, 1'b1, 1'b1, 32'd1);

        // UART write
        rnd = 8'($random(seed));
        exp_byte = rnd;
        bus_request(`IO_BASE + `ADDR_UART_TX, {24'd0, rnd}, 1'b1, KIND_UART, 1'b0, 1'b1, '0);

        // SPI chip select and a data byte
        bus_request(`IO_BASE + `ADDR_SPI_CS, '0, 1'b1, KIND_CS, 1'b1, 1'b1, 32'd0);
        bus_request(`IO_BASE + `ADDR_SPI_CS, '0, 1'b0, KIND_CS, 1'b1, 1'b1, 32'd0);
        @(posedge clk);
        slave_next <= 8'($random(seed));
        slave_load <= 1'b1;
        @(posedge clk);
        slave_load <= 1'b0;
        rnd = 8'($random(seed));
        exp_byte = rnd;
        bus_request(`IO_BASE + `ADDR_SPI_DATA, {24'd0, rnd}, 1'b1, KIND_SPI_WR, 1'b0, 1'b1,
                    {24'd0, slave_next});
        bus_request(`IO_BASE + `ADDR_SPI_DATA, '0, 1'b0, KIND_REG, 1'b1, 1'b1,
                    {24'd0, slave_next});
        bus_request(`IO_BASE + `ADDR_SPI_CS, 32'd1, 1'b1, KIND_CS, 1'b1, 1'b1, 32'd1);

        // One-shot timer
        bus_request(`IO_BASE + `ADDR_TIMER_VALUE, TIMER_N, 1'b1, KIND_REG, 1'b1, 1'b1, '0);
        bus_request(`IO_BASE + `ADDR_TIMER_START, '0, 1'b1, KIND_REG, 1'b1, 1'b1, '0);
        @(negedge clk);
        while (timer_int !== 1'b1)
            @(negedge clk);
        repeat (30) @(posedge clk);   // Room for a stray second pulse

        // Micros and boot mode
        bus_request(`IO_BASE + `ADDR_MICROS, '0, 1'b0, KIND_MICROS1, 1'b1, 1'b0, '0);
        repeat (MICROS_GAP) @(posedge clk);
        bus_request(`IO_BASE + `ADDR_MICROS, '0, 1'b0, KIND_MICROS2, 1'b1, 1'b0, '0);
        bus_request(`IO_BASE + `ADDR_BOOT_MODE, '0, 1'b0, KIND_REG, 1'b1, 1'b1, 32'd0);
        @(posedge clk);
        boot_mode <= 1'b1;
        bus_request(`IO_BASE + `ADDR_BOOT_MODE, '0, 1'b0, KIND_REG, 1'b1, 1'b1, 32'd1);

        repeat (4) @(posedge clk);
        $display("*** TEST PASSED ***");
        $finish;
    end

endmodule
